// File: logic/imul_pkg.sv
package imul_pkg;

  // datapath widths
  localparam int xlen   = 64;
  localparam int prod_w = 2 * xlen;
  localparam int flag_w = 4;

  // flag vector bit positions
  localparam int flag_ovf  = 3;
  localparam int flag_sign = 2;
  localparam int flag_zero = 1;
  localparam int flag_par  = 0;

  // radix-4 booth on a 65-bit multiplier gives 33 digits,
  // plus one row that collects the negation bits
  localparam int booth_pp = (xlen + 2) / 2;
  localparam int pp_rows  = booth_pp + 1;

  // 3:2 levels to bring 34 rows down to two
  localparam int csa_levels = 8;

  typedef enum logic [2:0] {
    mul64     = 3'd0,
    imul64    = 3'd1,
    lmul64    = 3'd2,
    limul64   = 3'd3,
    mul32     = 3'd4,
    imul32    = 3'd5,
    mul32_64  = 3'd6,
    imul32_64 = 3'd7
  } op_t;

  // decoded control that rides along the pipe
  typedef struct packed {
    logic a_signed;
    logic b_signed;
    // operands come from the low 32 bits
    logic short_src;
    // take the high half of the product
    logic upper;
    // low 32 bits of the product, zero-extended
    logic narrow_res;
  } mul_ctl_t;

endpackage

// File: logic/imul_ctl_if.sv
`timescale 1ns/1ps

// valid strobe plus decoded control for one pipeline stage
interface imul_ctl_if;
  import imul_pkg::*;

  logic     valid;
  mul_ctl_t mode;

  // stage that registers and drives the control
  modport src (
    output valid,
    output mode
  );

  // stage that consumes it
  modport dst (
    input valid,
    input mode
  );

endinterface

// File: logic/imul_decode.sv
`timescale 1ns/1ps

module imul_decode (
  input  logic                clk,
  input  logic                rst,
  input  logic                clk_en,
  input  logic                in_valid,
  input  imul_pkg::op_t       op,
  output imul_pkg::mul_ctl_t  ctl_next,
  imul_ctl_if.src             ctl
);
  import imul_pkg::*;

  // combinational decode, also feeds the booth stage directly
  always_comb begin
    ctl_next = '0;
    case (op)
      mul64: ctl_next = '0;
      imul64: begin
        ctl_next.a_signed = 1'b1;
        ctl_next.b_signed = 1'b1;
      end
      lmul64: ctl_next.upper = 1'b1;
      limul64: begin
        ctl_next.a_signed = 1'b1;
        ctl_next.b_signed = 1'b1;
        ctl_next.upper    = 1'b1;
      end
      mul32: begin
        ctl_next.short_src  = 1'b1;
        ctl_next.narrow_res = 1'b1;
      end
      imul32: begin
        ctl_next.a_signed   = 1'b1;
        ctl_next.b_signed   = 1'b1;
        ctl_next.short_src  = 1'b1;
        ctl_next.narrow_res = 1'b1;
      end
      mul32_64: ctl_next.short_src = 1'b1;
      imul32_64: begin
        ctl_next.a_signed  = 1'b1;
        ctl_next.b_signed  = 1'b1;
        ctl_next.short_src = 1'b1;
      end
      default: ctl_next = '0;
    endcase
  end

  // stage 1 control register
  always_ff @(posedge clk) begin
    if (rst) begin
      ctl.valid <= 1'b0;
    end else if (clk_en) begin
      ctl.valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (clk_en) begin
      ctl.mode <= ctl_next;
    end
  end

endmodule

// File: logic/imul_ppgen.sv
`timescale 1ns/1ps

module imul_ppgen (
  input  logic                         clk,
  input  logic                         clk_en,
  input  logic [imul_pkg::xlen-1:0]    src_a,
  input  logic [imul_pkg::xlen-1:0]    src_b,
  input  logic                         a_signed,
  input  logic                         b_signed,
  input  logic                         short_src,
  output logic [imul_pkg::prod_w-1:0]  sum,
  output logic [imul_pkg::prod_w-1:0]  carry
);
  import imul_pkg::*;

  logic [xlen:0]     a_ext;
  logic [xlen:0]     b_ext;
  // multiplier with one extra sign bit on top and the implicit zero below
  logic [xlen+2:0]   b_booth;
  logic [prod_w-1:0] a_wide;
  logic [prod_w-1:0] rows [pp_rows];
  logic [prod_w-1:0] sum_c;
  logic [prod_w-1:0] carry_c;

  // 65-bit operands, so the unsigned 64-bit case is a positive signed value
  always_comb begin
    if (short_src) begin
      a_ext = {{(xlen/2+1){a_signed & src_a[xlen/2-1]}}, src_a[xlen/2-1:0]};
      b_ext = {{(xlen/2+1){b_signed & src_b[xlen/2-1]}}, src_b[xlen/2-1:0]};
    end else begin
      a_ext = {a_signed & src_a[xlen-1], src_a};
      b_ext = {b_signed & src_b[xlen-1], src_b};
    end
  end

  assign b_booth = {b_ext[xlen], b_ext, 1'b0};
  assign a_wide  = {{(prod_w-xlen-1){a_ext[xlen]}}, a_ext};

  // booth digits; a negative digit inverts the row and
  // drops its +1 into the last row at the row's weight
  always_comb begin
    logic [2:0]        grp;
    logic [prod_w-1:0] mag;
    logic [prod_w-1:0] corr;
    corr = '0;
    for (int i = 0; i < booth_pp; i++) begin
      grp = b_booth[2*i +: 3];
      case (grp)
        3'b001, 3'b010, 3'b101, 3'b110: mag = a_wide;
        3'b011, 3'b100:                 mag = a_wide << 1;
        default:                        mag = '0;
      endcase
      if (grp[2]) begin
        mag = ~mag;
      end
      rows[i]   = mag << (2 * i);
      corr[2*i] = grp[2];
    end
    rows[booth_pp] = corr;
  end

  // carry-save tree, groups of three rows per level, leftovers pass through
  always_comb begin
    logic [prod_w-1:0] t [pp_rows];
    logic [prod_w-1:0] x;
    logic [prod_w-1:0] y;
    logic [prod_w-1:0] z;
    int                n;
    int                m;
    t = rows;
    n = pp_rows;
    for (int lvl = 0; lvl < csa_levels; lvl++) begin
      m = 0;
      for (int i = 0; i < pp_rows; i += 3) begin
        if (i + 2 < n) begin
          x        = t[i];
          y        = t[i+1];
          z        = t[i+2];
          t[m]     = x ^ y ^ z;
          t[m+1]   = ((x & y) | (x & z) | (y & z)) << 1;
          m        = m + 2;
        end else if (i + 1 < n) begin
          x        = t[i];
          y        = t[i+1];
          t[m]     = x;
          t[m+1]   = y;
          m        = m + 2;
        end else if (i < n) begin
          x        = t[i];
          t[m]     = x;
          m        = m + 1;
        end
      end
      n = m;
    end
    sum_c   = t[0];
    carry_c = t[1];
  end

  // stage 1 register
  always_ff @(posedge clk) begin
    if (clk_en) begin
      sum   <= sum_c;
      carry <= carry_c;
    end
  end

endmodule

// File: logic/imul_final_add.sv
`timescale 1ns/1ps

module imul_final_add (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         clk_en,
  input  logic [imul_pkg::prod_w-1:0]  sum,
  input  logic [imul_pkg::prod_w-1:0]  carry,
  imul_ctl_if.dst                      ctl_in,
  imul_ctl_if.src                      ctl_out,
  output logic [imul_pkg::prod_w-1:0]  prod
);

  // stage 2 valid
  always_ff @(posedge clk) begin
    if (rst) begin
      ctl_out.valid <= 1'b0;
    end else if (clk_en) begin
      ctl_out.valid <= ctl_in.valid;
    end
  end

  // carry-propagate add modulo 2^128
  always_ff @(posedge clk) begin
    if (clk_en) begin
      ctl_out.mode <= ctl_in.mode;
      prod         <= sum + carry;
    end
  end

endmodule

// File: logic/imul_flags.sv
`timescale 1ns/1ps

module imul_flags (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         clk_en,
  input  logic [imul_pkg::prod_w-1:0]  prod,
  imul_ctl_if.dst                      ctl,
  output logic                         out_valid,
  output logic [imul_pkg::xlen-1:0]    result,
  output logic [imul_pkg::flag_w-1:0]  flags
);
  import imul_pkg::*;

  localparam int half = xlen / 2;

  logic [xlen-1:0]   res_c;
  logic [flag_w-1:0] flags_c;
  logic              ovf_c;

  // result view
  always_comb begin
    if (ctl.mode.narrow_res) begin
      res_c = {{half{1'b0}}, prod[half-1:0]};
    end else if (ctl.mode.upper) begin
      res_c = prod[prod_w-1:xlen];
    end else begin
      res_c = prod[xlen-1:0];
    end
  end

  // overflow only for the truncating views
  always_comb begin
    if (ctl.mode.narrow_res) begin
      ovf_c = prod[xlen-1:half] != {half{ctl.mode.a_signed & prod[half-1]}};
    end else if (ctl.mode.upper || ctl.mode.short_src) begin
      ovf_c = 1'b0;
    end else begin
      ovf_c = prod[prod_w-1:xlen] != {xlen{ctl.mode.a_signed & prod[xlen-1]}};
    end
  end

  always_comb begin
    flags_c            = '0;
    flags_c[flag_ovf]  = ovf_c;
    flags_c[flag_sign] = ctl.mode.narrow_res ? res_c[half-1] : res_c[xlen-1];
    flags_c[flag_zero] = ~|res_c;
    // even parity over the low byte
    flags_c[flag_par]  = ~^res_c[7:0];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (clk_en) begin
      out_valid <= ctl.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (clk_en) begin
      result <= res_c;
      flags  <= flags_c;
    end
  end

endmodule

// File: logic/imul_top.sv
`timescale 1ns/1ps

module imul_top (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         clk_en,
  input  logic                         in_valid,
  input  imul_pkg::op_t                op,
  input  logic [imul_pkg::xlen-1:0]    src_a,
  input  logic [imul_pkg::xlen-1:0]    src_b,
  output logic                         out_valid,
  output logic [imul_pkg::xlen-1:0]    result,
  output logic [imul_pkg::flag_w-1:0]  flags
);
  import imul_pkg::*;

  // unregistered decode for the booth stage
  mul_ctl_t          ctl_next;
  logic [prod_w-1:0] sum_s1;
  logic [prod_w-1:0] carry_s1;
  logic [prod_w-1:0] prod_s2;

  imul_ctl_if ctl_s1 ();
  imul_ctl_if ctl_s2 ();

  imul_decode i_imul_decode (
    .clk      (clk),
    .rst      (rst),
    .clk_en   (clk_en),
    .in_valid (in_valid),
    .op       (op),
    .ctl_next (ctl_next),
    .ctl      (ctl_s1.src)
  );

  imul_ppgen i_imul_ppgen (
    .clk       (clk),
    .clk_en    (clk_en),
    .src_a     (src_a),
    .src_b     (src_b),
    .a_signed  (ctl_next.a_signed),
    .b_signed  (ctl_next.b_signed),
    .short_src (ctl_next.short_src),
    .sum       (sum_s1),
    .carry     (carry_s1)
  );

  imul_final_add i_imul_final_add (
    .clk     (clk),
    .rst     (rst),
    .clk_en  (clk_en),
    .sum     (sum_s1),
    .carry   (carry_s1),
    .ctl_in  (ctl_s1.dst),
    .ctl_out (ctl_s2.src),
    .prod    (prod_s2)
  );

  imul_flags i_imul_flags (
    .clk       (clk),
    .rst       (rst),
    .clk_en    (clk_en),
    .prod      (prod_s2),
    .ctl       (ctl_s2.dst),
    .out_valid (out_valid),
    .result    (result),
    .flags     (flags)
  );

endmodule

// File: verif/imul_properties.sv
`timescale 1ns/1ps

module imul_properties (
  input logic                         clk,
  input logic                         rst,
  input logic                         clk_en,
  input logic                         in_valid,
  input logic                         out_valid,
  input logic [imul_pkg::xlen-1:0]    result,
  input logic [imul_pkg::flag_w-1:0]  flags
);

  // in_valid history shifted on enabled edges only
  logic [2:0] accepted;

  always_ff @(posedge clk) begin
    if (rst) begin
      accepted <= '0;
    end else if (clk_en) begin
      accepted <= {accepted[1:0], in_valid};
    end
  end

  out_valid_cleared_by_reset: assert property (@(posedge clk) rst |=> !out_valid)
    else $error("out_valid still high after a reset edge");

  // three enabled edges from in_valid to out_valid
  out_valid_latency: assert property (@(posedge clk) disable iff (rst)
    out_valid == accepted[2])
    else $error("out_valid does not follow in_valid by three enabled edges");

  valid_held_in_stall: assert property (@(posedge clk) disable iff (rst)
    !clk_en |=> $stable(out_valid))
    else $error("out_valid changed while clk_en was low");

  data_held_in_stall: assert property (@(posedge clk) disable iff (rst)
    !clk_en |=> ($stable(result) && $stable(flags)))
    else $error("result or flags changed while clk_en was low");

endmodule

bind imul_top imul_properties i_imul_properties (
  .clk       (clk),
  .rst       (rst),
  .clk_en    (clk_en),
  .in_valid  (in_valid),
  .out_valid (out_valid),
  .result    (result),
  .flags     (flags)
);

// File: verif/imul_tb.sv
`timescale 1ns/1ps

module imul_tb;
  import imul_pkg::*;

  logic        clk;
  logic        rst;
  logic        clk_en;
  logic        in_valid;
  op_t         op;
  logic [63:0] src_a;
  logic [63:0] src_b;
  logic        out_valid;
  logic [63:0] result;
  logic [3:0]  flags;

  integer      seed;
  int          gap;
  // expected {result, flags} in issue order
  logic [67:0] exp_q [$];
  logic [63:0] corners [10];

  imul_top i_imul_top (
    .clk       (clk),
    .rst       (rst),
    .clk_en    (clk_en),
    .in_valid  (in_valid),
    .op        (op),
    .src_a     (src_a),
    .src_b     (src_b),
    .out_valid (out_valid),
    .result    (result),
    .flags     (flags)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic stop_run();
    $display("RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic fail_value(input string name, input logic [63:0] got, input logic [63:0] want);
    $display("[FAIL] %0t: %s is %h, expected %h", $time, name, got, want);
    stop_run();
  endtask

  task automatic fail_text(input string msg);
    $display("error at %0t: %s", $time, msg);
    stop_run();
  endtask

  // expected result and flags from the operation rules
  function automatic logic [67:0] expected_out(input op_t o, input logic [63:0] a,
                                               input logic [63:0] b);
    logic signed [127:0] ea;
    logic signed [127:0] eb;
    logic signed [127:0] p;
    logic                sgn;
    logic                narrow;
    logic [63:0]         r;
    logic [3:0]          f;
    sgn = (o == imul64) || (o == limul64) || (o == imul32) || (o == imul32_64);
    narrow = (o == mul32) || (o == imul32);
    if (o == mul32 || o == imul32 || o == mul32_64 || o == imul32_64) begin
      ea = sgn ? {{96{a[31]}}, a[31:0]} : {96'b0, a[31:0]};
      eb = sgn ? {{96{b[31]}}, b[31:0]} : {96'b0, b[31:0]};
    end else begin
      ea = sgn ? {{64{a[63]}}, a} : {64'b0, a};
      eb = sgn ? {{64{b[63]}}, b} : {64'b0, b};
    end
    p = ea * eb;
    f = '0;
    case (o)
      mul64, imul64: begin
        r = p[63:0];
        f[flag_ovf] = p[127:64] != (sgn ? {64{p[63]}} : 64'b0);
      end
      lmul64, limul64: r = p[127:64];
      mul32, imul32: begin
        r = {32'b0, p[31:0]};
        f[flag_ovf] = p[63:32] != (sgn ? {32{p[31]}} : 32'b0);
      end
      default: r = p[63:0];
    endcase
    f[flag_sign] = narrow ? r[31] : r[63];
    f[flag_zero] = (r == 64'b0);
    // even number of ones in the low byte
    f[flag_par]  = ($countones(r[7:0]) % 2) == 0;
    return {r, f};
  endfunction

  function automatic logic pick_en();
    logic [31:0] r;
    r = $random(seed);
    return (r % 100) >= gap;
  endfunction

  function automatic logic [63:0] rand_operand();
    logic [31:0] hi;
    logic [31:0] lo;
    logic [31:0] pick;
    hi = $random(seed);
    lo = $random(seed);
    pick = $random(seed);
    case (pick[2:0])
      3'd0: return {{32{lo[31]}}, lo};
      3'd1: return {32'b0, lo};
      3'd2: return {hi, 32'b0};
      default: return {hi, lo};
    endcase
  endfunction

  // hold the operation until an enabled edge takes it
  task automatic send(input op_t o, input logic [63:0] a, input logic [63:0] b);
    int   tries;
    logic taken;
    in_valid = 1'b1;
    op = o;
    src_a = a;
    src_b = b;
    tries = 0;
    taken = 1'b0;
    while (!taken && tries < 1000) begin
      clk_en = pick_en();
      taken = clk_en;
      @(posedge clk);
      #1;
      tries++;
    end
    if (!taken) fail_text("timeout: operation was never accepted");
    exp_q.push_back(expected_out(o, a, b));
    in_valid = 1'b0;
  endtask

  task automatic send_random();
    logic [31:0] r;
    r = $random(seed);
    send(op_t'(r[2:0]), rand_operand(), rand_operand());
  endtask

  task automatic idle(input int cycles);
    in_valid = 1'b0;
    repeat (cycles) begin
      clk_en = pick_en();
      @(posedge clk);
      #1;
    end
  endtask

  task automatic drain();
    int waited;
    in_valid = 1'b0;
    waited = 0;
    while (exp_q.size() > 0 && waited < 200) begin
      clk_en = pick_en();
      @(posedge clk);
      #1;
      waited++;
    end
    if (exp_q.size() > 0) fail_text("timeout waiting for the pipeline to drain");
  endtask

  // compare on the negedge after each enabled edge with out_valid high
  initial begin : compare
    logic        en_edge;
    logic [67:0] want;
    forever begin
      @(posedge clk);
      en_edge = clk_en && !rst;
      @(negedge clk);
      if (en_edge && out_valid) begin
        assert (exp_q.size() > 0) else fail_text("out_valid with no operation outstanding");
        want = exp_q.pop_front();
        assert (result === want[67:4]) else fail_value("result", result, want[67:4]);
        assert (flags === want[3:0])
          else fail_value("flags", {60'b0, flags}, {60'b0, want[3:0]});
      end
    end
  end

  initial begin : stimulus
    seed = 42;
    gap = 0;
    rst = 1'b1;
    clk_en = 1'b1;
    in_valid = 1'b0;
    op = mul64;
    src_a = '0;
    src_b = '0;
    corners = '{64'h0, 64'h1, '1, 64'h8000_0000_0000_0000, 64'h7fff_ffff_ffff_ffff,
                64'h0000_0000_ffff_ffff, 64'h0000_0000_8000_0000, 64'h0000_0000_7fff_ffff,
                64'h0000_0001_0000_0000, 64'hffff_ffff_0000_0000};
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    // corners for every op back to back
    for (int o = 0; o < 8; o++) begin
      foreach (corners[i]) begin
        foreach (corners[j]) send(op_t'(o[2:0]), corners[i], corners[j]);
      end
    end
    // products that just fit or just miss
    send(imul64, 64'h8000_0000, 64'hffff_ffff_0000_0000);
    send(imul64, 64'h8000_0000, 64'h1_0000_0000);
    send(imul64, '1, 64'h8000_0000_0000_0000);
    send(mul64, 64'h1_0000_0000, 64'h1_0000_0000);
    send(mul64, 64'hffff_ffff, 64'h1_0000_0001);
    send(imul32, 64'hffff_8000, 64'h1_0000);
    send(imul32, 64'h8000, 64'h1_0000);
    send(mul32, 64'h1_0000, 64'h1_0000);
    send(mul32, 64'hffff, 64'h1_0001);
    // random stalls
    gap = 40;
    repeat (300) send_random();
    drain();
    // reset with operations in flight
    gap = 0;
    repeat (3) send_random();
    rst = 1'b1;
    @(posedge clk);
    #1;
    exp_q.delete();
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    idle(12);
    gap = 10;
    repeat (2000) send_random();
    drain();
    if (exp_q.size() == 0) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      $display("RESULT: FAIL");
      $fatal(1, "operations left outstanding");
    end
  end

endmodule

// File: build.f
logic/imul_pkg.sv
logic/imul_ctl_if.sv
logic/imul_decode.sv
logic/imul_ppgen.sv
logic/imul_final_add.sv
logic/imul_flags.sv
logic/imul_top.sv
verif/imul_properties.sv
verif/imul_tb.sv

// File: Makefile
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert -Wno-fatal
TOP      ?= imul_tb
FILELIST ?= build.f
PASS_MSG := RESULT: PASS
OBJ_DIR  := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(SIM) and run $(TOP), fails unless the pass line is printed"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
